// ==== common/mask_pkg.sv ====
`default_nettype none

package mask_pkg;

	// default widths of the image coordinates and the output pixel.
	localparam int COL_W   = 12;
	localparam int ROW_W   = 12;
	localparam int PIXEL_W = 1;

	// column index or image width.
	typedef logic [COL_W-1:0] col_t;

	// row index or image height.
	typedef logic [ROW_W-1:0] row_t;

	// value written into the output stream for one pixel.
	typedef logic [PIXEL_W-1:0] pixel_t;

	// the scanner waits in SCAN_IDLE for a frame sync.
	// It stays in SCAN_RUN until the last pixel of the frame is issued.
	typedef enum logic [0:0] {
		SCAN_IDLE,
		SCAN_RUN
	} scan_state_t;

endpackage

`default_nettype wire

// ==== hw/stream_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module stream_fifo #(
	parameter int DATA_W          = 3,
	parameter int FIFO_DEPTH_LOG2 = 3,
	parameter int FIFO_NEAR_FULL  = 4
)(
	input  wire               clk,
	input  wire               resetn,
	input  wire               we,
	input  wire  [DATA_W-1:0] wr_data,
	input  wire               rd,
	output logic [DATA_W-1:0] rd_data,
	output logic              empty,
	output logic              near_full
);
	localparam int DEPTH = 2**FIFO_DEPTH_LOG2;
	localparam logic [FIFO_DEPTH_LOG2:0] NF_LEVEL   = (FIFO_DEPTH_LOG2+1)'(FIFO_NEAR_FULL);
	localparam logic [FIFO_DEPTH_LOG2:0] FULL_LEVEL = (FIFO_DEPTH_LOG2+1)'(DEPTH);

	logic [DATA_W-1:0]        mem [DEPTH];
	logic [FIFO_DEPTH_LOG2-1:0] wr_ptr;
	logic [FIFO_DEPTH_LOG2-1:0] rd_ptr;
	logic [FIFO_DEPTH_LOG2:0]   count;
	logic                       full;

	assign rd_data   = mem[rd_ptr];	// head word is visible before it is popped.
	assign empty     = (count == '0);
	assign full      = (count == FULL_LEVEL);
	assign near_full = (count >= NF_LEVEL);

	always_ff @(posedge clk) begin
		if (we)
			mem[wr_ptr] <= wr_data;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (we)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({we, rd})
			2'b10:   count <= count + 1'b1;
			2'b01:   count <= count - 1'b1;
			default: count <= count;
			endcase
		end
	end

	// the producer stops early enough that the pipeline drains into the free slots.
	assert property (@(posedge clk) disable iff (!resetn)
		!(we && full) && !(rd && empty))
		else $error("stream_fifo: overflow or underflow");

endmodule

`default_nettype wire

// ==== hw/mask_gen/raster_scan.sv ====
`timescale 1ns/1ns
`default_nettype none

module raster_scan import mask_pkg::*; (
	input  wire        clk,
	input  wire        resetn,
	input  wire        fsync,
	input  wire col_t  width,
	input  wire row_t  height,
	input  wire        near_full,
	output logic       pix_rd,
	output col_t       pix_col,
	output row_t       pix_row,
	output logic       pix_first,
	output logic       pix_eol
);
	scan_state_t state;
	logic        armed;
	logic        col_last;
	logic        row_last;
	logic        last_pix;

	assign last_pix  = col_last && row_last;
	assign pix_rd    = armed && !near_full;	// one pixel per cycle while the fifo has room.
	assign pix_first = (pix_col == '0) && (pix_row == '0);
	assign pix_eol   = col_last;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= SCAN_IDLE;
			armed <= 1'b0;
		end else begin
			case (state)
			SCAN_IDLE: begin
				if (fsync)
					state <= SCAN_RUN;
			end
			SCAN_RUN: begin
				if (pix_rd && last_pix)
					state <= SCAN_IDLE;
			end
			default: state <= SCAN_IDLE;
			endcase
			// reads start one cycle after the frame is entered.
			armed <= (state == SCAN_RUN) && !(pix_rd && last_pix);
		end
	end

	// the last flags are set one pixel ahead so the wrap needs no compare on the hot path.
	always_ff @(posedge clk) begin
		if (!resetn) begin
			pix_col  <= '0;
			pix_row  <= '0;
			col_last <= 1'b0;
			row_last <= 1'b0;
		end else if (state == SCAN_IDLE && fsync) begin
			pix_col  <= '0;
			pix_row  <= '0;
			col_last <= 1'b0;	// width and height are at least 2.
			row_last <= 1'b0;
		end else if (pix_rd) begin
			if (col_last) begin
				pix_col  <= '0;
				col_last <= 1'b0;
				if (row_last)
					pix_row <= '0;
				else
					pix_row <= pix_row + row_t'(1);
				row_last <= (pix_row == height - row_t'(2));
			end else begin
				pix_col  <= pix_col + col_t'(1);
				col_last <= (pix_col == width - col_t'(2));
			end
		end
	end

	// a new frame may only be started once the previous one has been issued.
	assert property (@(posedge clk) disable iff (!resetn)
		(state == SCAN_RUN) |-> !fsync)
		else $error("raster_scan: fsync while a frame is running");

endmodule

`default_nettype wire

// ==== hw/mask_gen/column_span_test.sv ====
`timescale 1ns/1ns
`default_nettype none

module column_span_test import mask_pkg::*; (
	input  wire        clk,
	input  wire        resetn,
	input  wire        span_we,
	input  wire col_t  span_col,
	input  wire row_t  span_top,
	input  wire row_t  span_bottom,
	input  wire        span_valid,
	input  wire        pix_rd,
	input  wire col_t  pix_col,
	input  wire row_t  pix_row,
	output logic       col_hit_valid,
	output logic       col_hit
);
	localparam int BOT_B  = 0;
	localparam int TOP_B  = BOT_B + ROW_W;
	localparam int VBIT   = TOP_B + ROW_W;
	localparam int SPAN_W = VBIT + 1;

	typedef logic [SPAN_W-1:0] span_word_t;

	span_word_t span_mem [2**COL_W];

	span_word_t rd_word;
	row_t       row_s1;
	logic       rd_s1;

	logic       ent_valid;
	row_t       ent_top;
	row_t       ent_bottom;
	row_t       row_s2;
	logic       rd_s2;

	// one table word per column, written by the host between frames.
	always_ff @(posedge clk) begin
		if (span_we)
			span_mem[span_col] <= {span_valid, span_top, span_bottom};
		rd_word <= span_mem[pix_col];
		row_s1  <= pix_row;
	end

	always_ff @(posedge clk) begin
		ent_valid  <= rd_word[VBIT];
		ent_top    <= rd_word[VBIT-1:TOP_B];
		ent_bottom <= rd_word[TOP_B-1:BOT_B];
		row_s2     <= row_s1;
	end

	always_ff @(posedge clk) begin
		col_hit <= ent_valid && (row_s2 >= ent_top) && (row_s2 <= ent_bottom);
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			rd_s1         <= 1'b0;
			rd_s2         <= 1'b0;
			col_hit_valid <= 1'b0;
		end else begin
			rd_s1         <= pix_rd;
			rd_s2         <= rd_s1;
			col_hit_valid <= rd_s2;	// three cycles after the read strobe.
		end
	end

	// the host only rewrites the table while the scanner is idle.
	assert property (@(posedge clk) disable iff (!resetn)
		!(span_we && pix_rd))
		else $error("column_span_test: span write during a pixel read");

endmodule

`default_nettype wire

// ==== hw/mask_gen/window_test.sv ====
`timescale 1ns/1ns
`default_nettype none

module window_test import mask_pkg::*; (
	input  wire        clk,
	input  wire        resetn,
	input  wire col_t  win_left,
	input  wire col_t  win_right,
	input  wire        pix_rd,
	input  wire col_t  pix_col,
	input  wire        pix_first,
	input  wire        pix_eol,
	output logic       win_hit_valid,
	output logic       win_hit,
	output logic       tag_first,
	output logic       tag_eol
);
	logic rd_d1;
	logic rd_d2;
	col_t col_d1;
	col_t col_d2;
	logic first_d1;
	logic first_d2;
	logic eol_d1;
	logic eol_d2;

	// two delay stages line up with the table read and decode of the span test.
	always_ff @(posedge clk) begin
		col_d1    <= pix_col;
		col_d2    <= col_d1;
		first_d1  <= pix_first;
		first_d2  <= first_d1;
		eol_d1    <= pix_eol;
		eol_d2    <= eol_d1;
		win_hit   <= (col_d2 >= win_left) && (col_d2 <= win_right);	// empty if left > right.
		tag_first <= first_d2;
		tag_eol   <= eol_d2;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			rd_d1         <= 1'b0;
			rd_d2         <= 1'b0;
			win_hit_valid <= 1'b0;
		end else begin
			rd_d1         <= pix_rd;
			rd_d2         <= rd_d1;
			win_hit_valid <= rd_d2;
		end
	end

endmodule

`default_nettype wire

// ==== hw/mask_gen/mask_merge.sv ====
`timescale 1ns/1ns
`default_nettype none

module mask_merge import mask_pkg::*; #(
	parameter pixel_t ON_VALUE = pixel_t'(1)
)(
	input  wire                      clk,
	input  wire                      resetn,
	input  wire                      col_hit_valid,
	input  wire                      col_hit,
	input  wire                      win_hit_valid,
	input  wire                      win_hit,
	input  wire                      tag_first,
	input  wire                      tag_eol,
	input  wire  [PIXEL_W+1:0]       fifo_rd_data,
	input  wire                      fifo_empty,
	input  wire                      m_tready,
	output logic                     fifo_we,
	output logic [PIXEL_W+1:0]       fifo_wr_data,
	output logic                     fifo_rd,
	output logic                     m_tvalid,
	output pixel_t                   m_tdata,
	output logic                     m_tuser,
	output logic                     m_tlast
);
	// the flags sit in the low bits of a fifo word and the pixel sits above them.
	localparam int FD_SOF  = 0;
	localparam int FD_LAST = 1;
	localparam int FD_DATA = 2;

	pixel_t pix_val;

	assign pix_val = (col_hit && win_hit) ? ON_VALUE : '0;

	always_ff @(posedge clk) begin
		if (!resetn)
			fifo_we <= 1'b0;
		else
			fifo_we <= col_hit_valid && win_hit_valid;
	end

	always_ff @(posedge clk) begin
		if (col_hit_valid)
			fifo_wr_data <= {pix_val, tag_eol, tag_first};
	end

	// refill the output register when it is empty or its beat leaves this cycle.
	assign fifo_rd = (!m_tvalid || m_tready) && !fifo_empty;

	always_ff @(posedge clk) begin
		if (!resetn)
			m_tvalid <= 1'b0;
		else if (fifo_rd)
			m_tvalid <= 1'b1;
		else if (m_tready)
			m_tvalid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (fifo_rd) begin
			m_tdata <= fifo_rd_data[FD_DATA +: PIXEL_W];
			m_tuser <= fifo_rd_data[FD_SOF];
			m_tlast <= fifo_rd_data[FD_LAST];
		end
	end

	// both test pipelines have the same fixed latency from the scanner.
	assert property (@(posedge clk) disable iff (!resetn)
		col_hit_valid == win_hit_valid)
		else $error("mask_merge: span and window results out of step");

endmodule

`default_nettype wire

// ==== hw/mask_gen/mask_gen_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module mask_gen_top import mask_pkg::*; #(
	parameter pixel_t ON_VALUE        = pixel_t'(1),
	parameter int     FIFO_DEPTH_LOG2 = 3,
	parameter int     FIFO_NEAR_FULL  = 4
)(
	input  wire         clk,
	input  wire         resetn,
	input  wire row_t   height,
	input  wire col_t   width,
	input  wire col_t   win_left,
	input  wire col_t   win_right,
	input  wire         span_we,
	input  wire col_t   span_col,
	input  wire row_t   span_top,
	input  wire row_t   span_bottom,
	input  wire         span_valid,
	input  wire         fsync,
	output logic        m_tvalid,
	output pixel_t      m_tdata,
	output logic        m_tuser,
	output logic        m_tlast,
	input  wire         m_tready
);
	localparam int FIFO_DW = PIXEL_W + 2;	// pixel plus frame and row tags.

	logic               pix_rd;
	col_t               pix_col;
	row_t               pix_row;
	logic               pix_first;
	logic               pix_eol;
	logic               col_hit_valid;
	logic               col_hit;
	logic               win_hit_valid;
	logic               win_hit;
	logic               tag_first;
	logic               tag_eol;
	logic               fifo_we;
	logic [FIFO_DW-1:0] fifo_wr_data;
	logic               fifo_rd;
	logic [FIFO_DW-1:0] fifo_rd_data;
	logic               fifo_empty;
	logic               near_full;

	raster_scan scan_i (
		.clk(clk), .resetn(resetn), .fsync(fsync), .width(width), .height(height),
		.near_full(near_full), .pix_rd(pix_rd), .pix_col(pix_col), .pix_row(pix_row),
		.pix_first(pix_first), .pix_eol(pix_eol)
	);

	column_span_test span_i (
		.clk(clk), .resetn(resetn), .span_we(span_we), .span_col(span_col),
		.span_top(span_top), .span_bottom(span_bottom), .span_valid(span_valid),
		.pix_rd(pix_rd), .pix_col(pix_col), .pix_row(pix_row),
		.col_hit_valid(col_hit_valid), .col_hit(col_hit)
	);

	window_test win_i (
		.clk(clk), .resetn(resetn), .win_left(win_left), .win_right(win_right),
		.pix_rd(pix_rd), .pix_col(pix_col), .pix_first(pix_first), .pix_eol(pix_eol),
		.win_hit_valid(win_hit_valid), .win_hit(win_hit),
		.tag_first(tag_first), .tag_eol(tag_eol)
	);

	mask_merge #(.ON_VALUE(ON_VALUE)) merge_i (
		.clk(clk), .resetn(resetn), .col_hit_valid(col_hit_valid), .col_hit(col_hit),
		.win_hit_valid(win_hit_valid), .win_hit(win_hit), .tag_first(tag_first),
		.tag_eol(tag_eol), .fifo_rd_data(fifo_rd_data), .fifo_empty(fifo_empty),
		.m_tready(m_tready), .fifo_we(fifo_we), .fifo_wr_data(fifo_wr_data),
		.fifo_rd(fifo_rd), .m_tvalid(m_tvalid), .m_tdata(m_tdata),
		.m_tuser(m_tuser), .m_tlast(m_tlast)
	);

	stream_fifo #(
		.DATA_W(FIFO_DW),
		.FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2),
		.FIFO_NEAR_FULL(FIFO_NEAR_FULL)
	) fifo_i (
		.clk(clk), .resetn(resetn), .we(fifo_we), .wr_data(fifo_wr_data),
		.rd(fifo_rd), .rd_data(fifo_rd_data), .empty(fifo_empty), .near_full(near_full)
	);

endmodule

`default_nettype wire

// ==== bench/mask_model.svh ====
`ifndef MASK_MODEL_SVH
`define MASK_MODEL_SVH

localparam int MODEL_COLS = 32;

// span table and window as the host last programmed them.
logic model_valid [MODEL_COLS];
row_t model_top [MODEL_COLS];
row_t model_bottom [MODEL_COLS];
col_t model_width;
row_t model_height;
col_t model_left;
col_t model_right;

function automatic pixel_t expected_pixel(input col_t col, input row_t row);
	logic in_span;
	logic in_win;
	in_span = model_valid[col[4:0]] && (model_top[col[4:0]] <= row)
		&& (row <= model_bottom[col[4:0]]);
	in_win = (model_left <= col) && (col <= model_right);	// empty when left > right.
	return (in_span && in_win) ? ON_VALUE : '0;
endfunction

function automatic logic expected_first(input col_t col, input row_t row);
	return (col == '0) && (row == '0);
endfunction

function automatic logic expected_last(input col_t col);
	return col == model_width - col_t'(1);
endfunction

`endif

// ==== bench/mask_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module mask_tb import mask_pkg::*; ();
	localparam pixel_t ON_VALUE = pixel_t'(1);
	localparam int FRAMES = 7;

	logic clk = 1'b0;
	logic resetn;
	row_t height;
	col_t width;
	col_t win_left;
	col_t win_right;
	logic span_we;
	col_t span_col;
	row_t span_top;
	row_t span_bottom;
	logic span_valid;
	logic fsync;
	logic m_tready;
	logic m_tvalid;
	pixel_t m_tdata;
	logic m_tuser;
	logic m_tlast;

	logic [31:0] rng = 32'heee6;
	int errors = 0;
	int test_errors;
	int tests_run = 0;
	int tests_failed = 0;
	int test_num;
	string test_name;
	col_t cur_col = '0;
	row_t cur_row = '0;
	int frame_w [FRAMES];
	int frame_h [FRAMES];
	int watch_cycles = 0;

	`include "mask_model.svh"

	mask_gen_top #(.ON_VALUE(ON_VALUE), .FIFO_DEPTH_LOG2(3), .FIFO_NEAR_FULL(4)) dut_i (.*);

	always #5 clk = ~clk;

	initial begin
		wait (watch_cycles > 0);
		repeat (watch_cycles) @(posedge clk);
		$display("timeout: the run did not finish within %0d cycles", watch_cycles);
		$display("FAIL: see errors above");
		$finish;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	function automatic int unsigned rand_below(input int unsigned n);
		rng = xorshift32(rng);
		return rng % n;
	endfunction

	task automatic check_pixel(input string name, input pixel_t got, input pixel_t exp);
		if (got !== exp) begin
			errors++;
			test_errors++;
			$display("mismatch %s: got 0x%0h, expected 0x%0h (test %0d, row %0d, col %0d)",
				name, got, exp, test_num, cur_row, cur_col);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			errors++;
			test_errors++;
			$display("mismatch %s: got 0x%0h, expected 0x%0h (test %0d, row %0d, col %0d)",
				name, got, exp, test_num, cur_row, cur_col);
		end
	endtask

	task automatic begin_test(input int num, input string name);
		test_num = num;
		test_name = name;
		test_errors = 0;
		tests_run++;
	endtask

	task automatic end_test();
		if (test_errors == 0)
			$display("test %0d %s: ok", test_num, test_name);
		else begin
			tests_failed++;
			$display("test %0d %s: %0d errors", test_num, test_name, test_errors);
		end
	endtask

	task automatic write_span(input col_t col, input logic valid, input row_t top,
		input row_t bottom);
		@(posedge clk);
		span_we <= 1'b1;
		span_col <= col;
		span_valid <= valid;
		span_top <= top;
		span_bottom <= bottom;
		model_valid[col[4:0]] = valid;
		model_top[col[4:0]] = top;
		model_bottom[col[4:0]] = bottom;
	endtask

	task automatic random_table(input int w, input int h);
		for (int c = 0; c < w; c++)
			write_span(col_t'(c), rand_below(4) != 0, row_t'(rand_below(h + 1)),
				row_t'(rand_below(h + 1)));
		@(posedge clk);
		span_we <= 1'b0;
	endtask

	task automatic set_frame(input int w, input int h, input int left, input int right);
		@(posedge clk);
		width <= col_t'(w);
		height <= row_t'(h);
		win_left <= col_t'(left);
		win_right <= col_t'(right);
		model_width = col_t'(w);
		model_height = row_t'(h);
		model_left = col_t'(left);
		model_right = col_t'(right);
	endtask

	// beats arrive in raster order, so the expected position just counts accepted beats.
	task automatic run_frame(input int unsigned ready_pct);
		int total;
		int beats;
		logic holding;
		pixel_t held_data;
		logic held_user;
		logic held_last;
		total = int'(model_width) * int'(model_height);
		beats = 0;
		holding = 1'b0;
		cur_col = '0;
		cur_row = '0;
		@(posedge clk);
		fsync <= 1'b1;
		@(posedge clk);
		fsync <= 1'b0;
		while (beats < total) begin
			@(posedge clk);
			if (holding) begin
				check_flag("m_tvalid", m_tvalid, 1'b1);
				check_pixel("m_tdata", m_tdata, held_data);
				check_flag("m_tuser", m_tuser, held_user);
				check_flag("m_tlast", m_tlast, held_last);
			end
			holding = m_tvalid && !m_tready;
			held_data = m_tdata;
			held_user = m_tuser;
			held_last = m_tlast;
			if (m_tvalid && m_tready) begin
				check_pixel("m_tdata", m_tdata, expected_pixel(cur_col, cur_row));
				check_flag("m_tuser", m_tuser, expected_first(cur_col, cur_row));
				check_flag("m_tlast", m_tlast, expected_last(cur_col));
				beats++;
				if (cur_col == model_width - col_t'(1)) begin
					cur_col = '0;
					cur_row = cur_row + row_t'(1);
				end else
					cur_col = cur_col + col_t'(1);
			end
			m_tready <= (rand_below(100) < ready_pct);
		end
		m_tready <= 1'b1;
		repeat (4) begin
			@(posedge clk);
			check_flag("m_tvalid", m_tvalid, 1'b0);	// nothing may follow the last pixel.
		end
	endtask

	initial begin
		int total_pix;
		int left;
		resetn <= 1'b0;
		height <= '0;
		width <= '0;
		win_left <= '0;
		win_right <= '0;
		span_we <= 1'b0;
		span_col <= '0;
		span_top <= '0;
		span_bottom <= '0;
		span_valid <= 1'b0;
		fsync <= 1'b0;
		m_tready <= 1'b1;
		total_pix = 0;
		for (int i = 0; i < FRAMES; i++) begin
			frame_w[i] = 2 + int'(rand_below(16));
			frame_h[i] = 2 + int'(rand_below(8));
			total_pix += frame_w[i] * frame_h[i];
		end
		total_pix += frame_w[0] * frame_h[0];	// frame 0 is scanned twice.
		watch_cycles = total_pix * 4 + 2000;
		repeat (3) @(posedge clk);
		resetn <= 1'b1;

		begin_test(1, "idle after reset");
		repeat (20) begin
			@(posedge clk);
			check_flag("m_tvalid", m_tvalid, 1'b0);
			check_flag("scan_state_idle", dut_i.scan_i.state == SCAN_IDLE, 1'b1);
		end
		end_test();

		begin_test(2, "random spans, full window");
		random_table(frame_w[0], frame_h[0]);
		set_frame(frame_w[0], frame_h[0], 0, frame_w[0] - 1);
		run_frame(100);
		end_test();

		begin_test(3, "same frame, random tready");
		run_frame(50);
		end_test();

		begin_test(4, "random window limits");
		random_table(frame_w[1], frame_h[1]);
		set_frame(frame_w[1], frame_h[1], rand_below(frame_w[1] + 2), rand_below(frame_w[1] + 2));
		run_frame(75);
		random_table(frame_w[2], frame_h[2]);
		left = 1 + int'(rand_below(frame_w[2]));
		set_frame(frame_w[2], frame_h[2], left, rand_below(left));
		run_frame(75);
		end_test();

		begin_test(5, "frame and row flags over several sizes");
		for (int i = 3; i < 6; i++) begin
			random_table(frame_w[i], frame_h[i]);
			set_frame(frame_w[i], frame_h[i], 0, frame_w[i] - 1);
			run_frame(75);
		end
		end_test();

		begin_test(6, "cleared and inverted spans");
		for (int c = 0; c < frame_w[6]; c++) begin
			case (c % 3)
			0: write_span(col_t'(c), 1'b0, '0, row_t'(frame_h[6] - 1));
			1: write_span(col_t'(c), 1'b1, row_t'(frame_h[6] - 1), '0);	// top below bottom.
			default: write_span(col_t'(c), 1'b1, '0, row_t'(frame_h[6] - 1));
			endcase
		end
		@(posedge clk);
		span_we <= 1'b0;
		set_frame(frame_w[6], frame_h[6], 0, frame_w[6] - 1);
		run_frame(75);
		end_test();

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+bench
common/mask_pkg.sv
hw/stream_fifo.sv
hw/mask_gen/raster_scan.sv
hw/mask_gen/column_span_test.sv
hw/mask_gen/window_test.sv
hw/mask_gen/mask_merge.sv
hw/mask_gen/mask_gen_top.sv
bench/mask_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	-f sources.f --top-module mask_tb -o mask_tb

out="$(./obj_dir/mask_tb)"
echo "$out"

grep -qx "PASS: all tests" <<< "$out"
